//--- hw/axi_lite_pkg.sv
package axi_lite_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Basic bus types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] addr_t;  // Byte address
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;   // One enable per byte lane

	// Only the two codes this slave can return
	typedef enum logic [1:0] {
		OKAY = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channel payloads that travel beside valid and ready
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		addr_t addr;
	} ar_t;

	typedef struct packed {
		addr_t addr;
	} aw_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
	} w_t;

	typedef struct packed {
		data_t data;
		resp_e resp;
	} r_t;

	typedef struct packed {
		resp_e resp;
	} b_t;

	// Defaults for the top level, which passes them down the tree
	localparam addr_t MEM_BASE = 32'h8000_0000;
	localparam int MEM_WORDS = 256;
	localparam int MAX_DELAY = 3;
	localparam logic [15:0] LFSR_SEED = 16'hace1;  // Must not be zero

endpackage

//--- hw/resp_delay.sv
module resp_delay #(
	parameter type payload_t = logic,
	parameter int MAX_DELAY = axi_lite_pkg::MAX_DELAY,
	parameter logic [15:0] LFSR_SEED = axi_lite_pkg::LFSR_SEED
) (
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input payload_t in_data,

	output logic out_valid,
	input logic out_ready,
	output payload_t out_data
);

	localparam int CNT_W = (MAX_DELAY > 0) ? $clog2(MAX_DELAY + 1) : 1;
	localparam logic [15:0] LFSR_TAPS = 16'hb400;  // x^16 + x^14 + x^13 + x^11 + 1

	logic full;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] delay;
	logic [15:0] lfsr;
	payload_t hold;

	assign in_ready = !full;  // One entry, so only an empty stage takes data
	assign out_valid = full && (count == '0);
	assign out_data = hold;

	// Low LFSR bits pick the wait, clamped so it never exceeds MAX_DELAY
	always_comb begin
		delay = lfsr[CNT_W-1:0];
		if (delay > CNT_W'(MAX_DELAY))
			delay = CNT_W'(MAX_DELAY);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
			count <= '0;
			lfsr <= LFSR_SEED;
		end else begin
			if (in_valid && in_ready) begin
				full <= 1'b1;
				count <= delay;
				// One Galois step per accepted response
				lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? LFSR_TAPS : 16'h0000);
			end else if (full) begin
				if (count != '0)
					count <= count - 1'b1;  // Still counting down
				else if (out_ready)
					full <= 1'b0;           // Taken by the master
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			hold <= in_data;
	end

	// A response held under back-pressure must not change or vanish
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- hw/sram_axi.sv
module sram_axi #(
	parameter axi_lite_pkg::addr_t MEM_BASE = axi_lite_pkg::MEM_BASE,
	parameter int MEM_WORDS = axi_lite_pkg::MEM_WORDS,
	parameter int MAX_DELAY = axi_lite_pkg::MAX_DELAY,
	parameter logic [15:0] LFSR_SEED = axi_lite_pkg::LFSR_SEED
) (
	input logic clk,
	input logic reset,

	input logic ar_valid,
	output logic ar_ready,
	input axi_lite_pkg::ar_t ar,

	input logic aw_valid,
	output logic aw_ready,
	input axi_lite_pkg::aw_t aw,

	input logic w_valid,
	output logic w_ready,
	input axi_lite_pkg::w_t w,

	output logic r_valid,
	input logic r_ready,
	output axi_lite_pkg::r_t r,

	output logic b_valid,
	input logic b_ready,
	output axi_lite_pkg::b_t b
);

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam axi_lite_pkg::addr_t WIN_BYTES = axi_lite_pkg::addr_t'(MEM_WORDS * 4);

	axi_lite_pkg::data_t mem [MEM_WORDS];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	axi_lite_pkg::addr_t rd_addr;
	axi_lite_pkg::addr_t rd_off;
	logic rd_hit;
	logic rd_pend;      // Address held and response not yet in the delay stage
	logic r_in_ready;
	axi_lite_pkg::r_t r_in;

	// Below MEM_BASE the offset wraps high, so one compare covers both ends
	assign rd_off = rd_addr - MEM_BASE;
	assign rd_hit = rd_off < WIN_BYTES;

	always_comb begin
		r_in.data = rd_hit ? mem[rd_off[IDX_W+1:2]] : '0;
		r_in.resp = rd_hit ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ar_ready <= 1'b1;
			rd_pend <= 1'b0;
		end else begin
			if (ar_valid && ar_ready) begin
				ar_ready <= 1'b0;  // Closed until the read completes
				rd_pend <= 1'b1;
			end
			if (rd_pend && r_in_ready)
				rd_pend <= 1'b0;
			if (r_valid && r_ready)
				ar_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready)
			rd_addr <= ar.addr;
	end

	resp_delay #(
		.payload_t(axi_lite_pkg::r_t),
		.MAX_DELAY(MAX_DELAY),
		.LFSR_SEED(LFSR_SEED)
	) r_dly_i (
		.clk(clk),
		.reset(reset),
		.in_valid(rd_pend),
		.in_ready(r_in_ready),
		.in_data(r_in),
		.out_valid(r_valid),
		.out_ready(r_ready),
		.out_data(r)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	axi_lite_pkg::addr_t wr_addr;
	axi_lite_pkg::addr_t wr_off;
	axi_lite_pkg::data_t wr_data;
	axi_lite_pkg::strb_t wr_strb;
	logic wr_hit;
	logic aw_held;
	logic w_held;
	logic b_push;
	logic b_in_ready;
	axi_lite_pkg::b_t b_in;

	assign wr_off = wr_addr - MEM_BASE;
	assign wr_hit = wr_off < WIN_BYTES;
	assign b_push = aw_held && w_held && b_in_ready;  // Both halves are in
	assign b_in.resp = wr_hit ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;

	always_ff @(posedge clk) begin
		if (reset) begin
			aw_ready <= 1'b1;
			w_ready <= 1'b1;
			aw_held <= 1'b0;
			w_held <= 1'b0;
		end else begin
			if (aw_valid && aw_ready) begin
				aw_ready <= 1'b0;
				aw_held <= 1'b1;
			end
			if (w_valid && w_ready) begin
				w_ready <= 1'b0;
				w_held <= 1'b1;
			end
			if (b_push) begin
				aw_held <= 1'b0;
				w_held <= 1'b0;
			end
			// Both channels reopen together once the master takes the response
			if (b_valid && b_ready) begin
				aw_ready <= 1'b1;
				w_ready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (aw_valid && aw_ready)
			wr_addr <= aw.addr;
		if (w_valid && w_ready) begin
			wr_data <= w.data;
			wr_strb <= w.strb;
		end
	end

	// Strobed bytes merge into the word and an out-of-window write changes nothing
	always_ff @(posedge clk) begin
		if (b_push && wr_hit) begin
			for (int i = 0; i < 4; i++) begin
				if (wr_strb[i])
					mem[wr_off[IDX_W+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
			end
		end
	end

	// The write response stage gets the byte-swapped seed so it runs its own sequence
	resp_delay #(
		.payload_t(axi_lite_pkg::b_t),
		.MAX_DELAY(MAX_DELAY),
		.LFSR_SEED({LFSR_SEED[7:0], LFSR_SEED[15:8]})
	) b_dly_i (
		.clk(clk),
		.reset(reset),
		.in_valid(aw_held && w_held),
		.in_ready(b_in_ready),
		.in_data(b_in),
		.out_valid(b_valid),
		.out_ready(b_ready),
		.out_data(b)
	);

	a_no_ar_overlap: assert property (@(posedge clk) disable iff (reset)
		(ar_valid && ar_ready) |-> !r_valid && !rd_pend);

	a_no_aw_overlap: assert property (@(posedge clk) disable iff (reset)
		((aw_valid && aw_ready) || (w_valid && w_ready)) |-> !b_valid);

endmodule

//--- hw/axi_lite_arbiter.sv
module axi_lite_arbiter (
	input logic clk,
	input logic reset,

	input logic m0_ar_valid,
	output logic m0_ar_ready,
	input axi_lite_pkg::ar_t m0_ar,
	input logic m0_aw_valid,
	output logic m0_aw_ready,
	input axi_lite_pkg::aw_t m0_aw,
	input logic m0_w_valid,
	output logic m0_w_ready,
	input axi_lite_pkg::w_t m0_w,
	output logic m0_r_valid,
	input logic m0_r_ready,
	output axi_lite_pkg::r_t m0_r,
	output logic m0_b_valid,
	input logic m0_b_ready,
	output axi_lite_pkg::b_t m0_b,

	input logic m1_ar_valid,
	output logic m1_ar_ready,
	input axi_lite_pkg::ar_t m1_ar,
	input logic m1_aw_valid,
	output logic m1_aw_ready,
	input axi_lite_pkg::aw_t m1_aw,
	input logic m1_w_valid,
	output logic m1_w_ready,
	input axi_lite_pkg::w_t m1_w,
	output logic m1_r_valid,
	input logic m1_r_ready,
	output axi_lite_pkg::r_t m1_r,
	output logic m1_b_valid,
	input logic m1_b_ready,
	output axi_lite_pkg::b_t m1_b,

	output logic s_ar_valid,
	input logic s_ar_ready,
	output axi_lite_pkg::ar_t s_ar,
	output logic s_aw_valid,
	input logic s_aw_ready,
	output axi_lite_pkg::aw_t s_aw,
	output logic s_w_valid,
	input logic s_w_ready,
	output axi_lite_pkg::w_t s_w,
	input logic s_r_valid,
	output logic s_r_ready,
	input axi_lite_pkg::r_t s_r,
	input logic s_b_valid,
	output logic s_b_ready,
	input axi_lite_pkg::b_t s_b
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic rd_busy;   // From ar transfer to r transfer
	logic rd_gnt;    // High when m1 owns the read or won it last
	logic rd_pick0;
	logic rd_pick1;

	// On a tie the master that lost last time goes first
	assign rd_pick1 = m1_ar_valid && (!m0_ar_valid || !rd_gnt);
	assign rd_pick0 = m0_ar_valid && (!m1_ar_valid || rd_gnt);

	assign s_ar_valid = !rd_busy && (m0_ar_valid || m1_ar_valid);
	assign s_ar = rd_pick1 ? m1_ar : m0_ar;
	assign m0_ar_ready = s_ar_ready && !rd_busy && !rd_pick1;
	assign m1_ar_ready = s_ar_ready && !rd_busy && !rd_pick0;

	assign m0_r_valid = s_r_valid && rd_busy && !rd_gnt;
	assign m1_r_valid = s_r_valid && rd_busy && rd_gnt;
	assign m0_r = s_r;
	assign m1_r = s_r;
	assign s_r_ready = rd_busy && (rd_gnt ? m1_r_ready : m0_r_ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_busy <= 1'b0;
			rd_gnt <= 1'b1;  // So m0 wins the first tie
		end else if (rd_busy) begin
			if (s_r_valid && s_r_ready)
				rd_busy <= 1'b0;
		end else if (s_ar_valid && s_ar_ready) begin
			rd_busy <= 1'b1;
			rd_gnt <= rd_pick1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write side where aw and w share one grant
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic wr_busy;   // From the first aw or w transfer to the b transfer
	logic wr_gnt;
	logic wr_req0;
	logic wr_req1;
	logic wr_pick0;
	logic wr_pick1;
	logic wr_sel;

	assign wr_req0 = m0_aw_valid || m0_w_valid;
	assign wr_req1 = m1_aw_valid || m1_w_valid;
	assign wr_pick1 = wr_req1 && (!wr_req0 || !wr_gnt);
	assign wr_pick0 = wr_req0 && (!wr_req1 || wr_gnt);
	assign wr_sel = wr_busy ? wr_gnt : wr_pick1;  // Locked once half of the write is in

	assign s_aw_valid = wr_sel ? m1_aw_valid : m0_aw_valid;
	assign s_aw = wr_sel ? m1_aw : m0_aw;
	assign s_w_valid = wr_sel ? m1_w_valid : m0_w_valid;
	assign s_w = wr_sel ? m1_w : m0_w;

	assign m0_aw_ready = s_aw_ready && (wr_busy ? !wr_gnt : !wr_pick1);
	assign m1_aw_ready = s_aw_ready && (wr_busy ? wr_gnt : !wr_pick0);
	assign m0_w_ready = s_w_ready && (wr_busy ? !wr_gnt : !wr_pick1);
	assign m1_w_ready = s_w_ready && (wr_busy ? wr_gnt : !wr_pick0);

	assign m0_b_valid = s_b_valid && wr_busy && !wr_gnt;
	assign m1_b_valid = s_b_valid && wr_busy && wr_gnt;
	assign m0_b = s_b;
	assign m1_b = s_b;
	assign s_b_ready = wr_busy && (wr_gnt ? m1_b_ready : m0_b_ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_busy <= 1'b0;
			wr_gnt <= 1'b1;
		end else if (wr_busy) begin
			if (s_b_valid && s_b_ready)
				wr_busy <= 1'b0;
		end else if ((s_aw_valid && s_aw_ready) || (s_w_valid && s_w_ready)) begin
			wr_busy <= 1'b1;
			wr_gnt <= wr_pick1;
		end
	end

	// A slave response only comes for a granted request and reaches exactly one master
	a_r_route: assert property (@(posedge clk) disable iff (reset)
		s_r_valid |-> rd_busy && $onehot({m0_r_valid, m1_r_valid}));

	a_b_route: assert property (@(posedge clk) disable iff (reset)
		s_b_valid |-> wr_busy && $onehot({m0_b_valid, m1_b_valid}));

endmodule

//--- hw/mem_subsys_top.sv
module mem_subsys_top #(
	parameter axi_lite_pkg::addr_t MEM_BASE = axi_lite_pkg::MEM_BASE,
	parameter int MEM_WORDS = axi_lite_pkg::MEM_WORDS,
	parameter int MAX_DELAY = axi_lite_pkg::MAX_DELAY
) (
	input logic clk,
	input logic reset,

	// Port m0 carries instruction fetch
	input logic m0_ar_valid,
	output logic m0_ar_ready,
	input axi_lite_pkg::ar_t m0_ar,
	input logic m0_aw_valid,
	output logic m0_aw_ready,
	input axi_lite_pkg::aw_t m0_aw,
	input logic m0_w_valid,
	output logic m0_w_ready,
	input axi_lite_pkg::w_t m0_w,
	output logic m0_r_valid,
	input logic m0_r_ready,
	output axi_lite_pkg::r_t m0_r,
	output logic m0_b_valid,
	input logic m0_b_ready,
	output axi_lite_pkg::b_t m0_b,

	// Port m1 carries loads and stores
	input logic m1_ar_valid,
	output logic m1_ar_ready,
	input axi_lite_pkg::ar_t m1_ar,
	input logic m1_aw_valid,
	output logic m1_aw_ready,
	input axi_lite_pkg::aw_t m1_aw,
	input logic m1_w_valid,
	output logic m1_w_ready,
	input axi_lite_pkg::w_t m1_w,
	output logic m1_r_valid,
	input logic m1_r_ready,
	output axi_lite_pkg::r_t m1_r,
	output logic m1_b_valid,
	input logic m1_b_ready,
	output axi_lite_pkg::b_t m1_b
);

	// Single bundle between arbiter and SRAM
	logic s_ar_valid;
	logic s_ar_ready;
	axi_lite_pkg::ar_t s_ar;
	logic s_aw_valid;
	logic s_aw_ready;
	axi_lite_pkg::aw_t s_aw;
	logic s_w_valid;
	logic s_w_ready;
	axi_lite_pkg::w_t s_w;
	logic s_r_valid;
	logic s_r_ready;
	axi_lite_pkg::r_t s_r;
	logic s_b_valid;
	logic s_b_ready;
	axi_lite_pkg::b_t s_b;

	axi_lite_arbiter arb_i (.*);  // Port names line up with the top level and s_ wires

	sram_axi #(
		.MEM_BASE(MEM_BASE),
		.MEM_WORDS(MEM_WORDS),
		.MAX_DELAY(MAX_DELAY),
		.LFSR_SEED(axi_lite_pkg::LFSR_SEED)  // The write stage derives its own seed from this one
	) sram_i (
		.clk(clk),
		.reset(reset),
		.ar_valid(s_ar_valid),
		.ar_ready(s_ar_ready),
		.ar(s_ar),
		.aw_valid(s_aw_valid),
		.aw_ready(s_aw_ready),
		.aw(s_aw),
		.w_valid(s_w_valid),
		.w_ready(s_w_ready),
		.w(s_w),
		.r_valid(s_r_valid),
		.r_ready(s_r_ready),
		.r(s_r),
		.b_valid(s_b_valid),
		.b_ready(s_b_ready),
		.b(s_b)
	);

endmodule

//--- tests/tb_mem_subsys.sv
module tb_mem_subsys;
	timeunit 1ns;
	timeprecision 100ps;

	localparam axi_lite_pkg::addr_t MEM_BASE = axi_lite_pkg::MEM_BASE;
	localparam int MEM_WORDS = axi_lite_pkg::MEM_WORDS;
	localparam int MAX_DELAY = axi_lite_pkg::MAX_DELAY;
	localparam int MAX_STALL = 3;      // Two random bits per back-pressure stretch
	localparam int RESET_CYCLES = 10;
	localparam int NUM_ROWS = 24;
	localparam int LIMIT = RESET_CYCLES + NUM_ROWS * (MAX_DELAY + MAX_STALL + 8);

	typedef enum logic [1:0] {
		OP_RD,
		OP_WR,
		OP_PAIR
	} op_e;

	typedef struct packed {
		logic port;
		op_e op;
		axi_lite_pkg::addr_t addr;
		axi_lite_pkg::data_t data;
		axi_lite_pkg::strb_t strb;
	} row_t;

	// A pair row reads addr on m0 and addr + 4 on m1 in the same cycle
	localparam row_t ROWS [NUM_ROWS] = '{
		'{1'b0, OP_WR, 32'h8000_0000, 32'h1122_3344, 4'hf},
		'{1'b0, OP_RD, 32'h8000_0000, 32'h0, 4'h0},
		'{1'b1, OP_WR, 32'h8000_0004, 32'ha5a5_5a5a, 4'hf},
		'{1'b1, OP_RD, 32'h8000_0004, 32'h0, 4'h0},
		'{1'b1, OP_RD, 32'h8000_0000, 32'h0, 4'h0},
		'{1'b0, OP_RD, 32'h8000_0004, 32'h0, 4'h0},
		'{1'b0, OP_WR, 32'h8000_0008, 32'hdead_beef, 4'hf},
		'{1'b1, OP_WR, 32'h8000_0008, 32'h0000_c0de, 4'h3},
		'{1'b0, OP_RD, 32'h8000_0008, 32'h0, 4'h0},
		'{1'b1, OP_WR, 32'h8000_0008, 32'h7700_0000, 4'h8},
		'{1'b1, OP_RD, 32'h8000_0008, 32'h0, 4'h0},
		'{1'b0, OP_WR, 32'h8000_0008, 32'h0055_0000, 4'h4},
		'{1'b1, OP_WR, 32'h8000_03fc, 32'h0bad_f00d, 4'hf},
		'{1'b0, OP_RD, 32'h8000_03fc, 32'h0, 4'h0},
		'{1'b1, OP_WR, 32'h7fff_fffc, 32'hffff_ffff, 4'hf},  // Just below the window
		'{1'b0, OP_WR, 32'h8000_0400, 32'hffff_ffff, 4'hf},  // First byte past the end
		'{1'b1, OP_RD, 32'h7fff_fffc, 32'h0, 4'h0},
		'{1'b0, OP_RD, 32'h8000_0400, 32'h0, 4'h0},
		'{1'b1, OP_RD, 32'h0000_0000, 32'h0, 4'h0},
		'{1'b0, OP_RD, 32'h8000_0000, 32'h0, 4'h0},
		'{1'b0, OP_PAIR, 32'h8000_0000, 32'h0, 4'h0},
		'{1'b1, OP_RD, 32'h8000_03fc, 32'h0, 4'h0},
		'{1'b0, OP_PAIR, 32'h8000_0004, 32'h0, 4'h0},
		'{1'b0, OP_PAIR, 32'h8000_0000, 32'h0, 4'h0}
	};

	logic clk;
	logic reset;
	logic ar_valid [2];
	logic ar_ready [2];
	axi_lite_pkg::ar_t ar [2];
	logic aw_valid [2];
	logic aw_ready [2];
	axi_lite_pkg::aw_t aw [2];
	logic w_valid [2];
	logic w_ready [2];
	axi_lite_pkg::w_t w [2];
	logic r_valid [2];
	logic r_ready [2];
	axi_lite_pkg::r_t r [2];
	logic b_valid [2];
	logic b_ready [2];
	axi_lite_pkg::b_t b [2];

	axi_lite_pkg::data_t shadow [MEM_WORDS];  // Expected memory contents
	logic [31:0] lfsr = 32'hadc6_39e5;
	int errors = 0;
	int cycle = 0;
	int r_seen = 0;   // Handshakes counted on the bus
	int b_seen = 0;

	mem_subsys_top #(
		.MEM_BASE(MEM_BASE),
		.MEM_WORDS(MEM_WORDS),
		.MAX_DELAY(MAX_DELAY)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.m0_ar_valid(ar_valid[0]),
		.m0_ar_ready(ar_ready[0]),
		.m0_ar(ar[0]),
		.m0_aw_valid(aw_valid[0]),
		.m0_aw_ready(aw_ready[0]),
		.m0_aw(aw[0]),
		.m0_w_valid(w_valid[0]),
		.m0_w_ready(w_ready[0]),
		.m0_w(w[0]),
		.m0_r_valid(r_valid[0]),
		.m0_r_ready(r_ready[0]),
		.m0_r(r[0]),
		.m0_b_valid(b_valid[0]),
		.m0_b_ready(b_ready[0]),
		.m0_b(b[0]),
		.m1_ar_valid(ar_valid[1]),
		.m1_ar_ready(ar_ready[1]),
		.m1_ar(ar[1]),
		.m1_aw_valid(aw_valid[1]),
		.m1_aw_ready(aw_ready[1]),
		.m1_aw(aw[1]),
		.m1_w_valid(w_valid[1]),
		.m1_w_ready(w_ready[1]),
		.m1_w(w[1]),
		.m1_r_valid(r_valid[1]),
		.m1_r_ready(r_ready[1]),
		.m1_r(r[1]),
		.m1_b_valid(b_valid[1]),
		.m1_b_ready(b_ready[1]),
		.m1_b(b[1])
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cycle counter, handshake counters and hang detection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		cycle <= cycle + 1;
		r_seen <= r_seen + int'(r_valid[0] && r_ready[0]) + int'(r_valid[1] && r_ready[1]);
		b_seen <= b_seen + int'(b_valid[0] && b_ready[0]) + int'(b_valid[1] && b_ready[1]);
		if (cycle >= LIMIT) begin
			$display("Timeout: the run hung and did not finish within %0d cycles", LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	// Each bit costs one Galois step and takes the fresh low bit
	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic bit in_window(input axi_lite_pkg::addr_t a);
		return a >= MEM_BASE && a < MEM_BASE + 32'(MEM_WORDS * 4);
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
		assert (got === exp) else begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// Holds ready low for stall cycles of valid, then takes the response
	task automatic take_resp(input int p, input bit is_rd, input int stall,
			output axi_lite_pkg::r_t got);
		axi_lite_pkg::r_t first;
		logic vld;
		logic rdy;
		bit seen;
		bit done;
		int n;
		seen = 0;
		done = 0;
		n = 0;
		first = '0;
		rdy = (stall == 0);
		while (!done) begin
			if (is_rd)
				r_ready[p] = rdy;
			else
				b_ready[p] = rdy;
			#1;
			if (is_rd) begin
				vld = r_valid[p];
				got = r[p];
			end else begin
				vld = b_valid[p];
				got.data = '0;
				got.resp = b[p].resp;
			end
			if (vld) begin
				if (seen)
					check($sformatf("m%0d_%s held payload", p, is_rd ? "r" : "b"),
						64'(first), 64'(got));
				first = got;
				seen = 1;
				done = rdy;  // Transfer on the coming rising edge
				n++;
			end else begin
				assert (!seen) else begin
					$display("Response valid on m%0d dropped before it was accepted", p);
					errors++;
				end
			end
			@(negedge clk);
			rdy = (n >= stall);
		end
		if (is_rd)
			r_ready[p] = 1'b0;
		else
			b_ready[p] = 1'b0;
	endtask

	task automatic do_read(input int p, input axi_lite_pkg::addr_t a, input int stall,
			output axi_lite_pkg::r_t got, output int acc);
		@(negedge clk);
		ar_valid[p] = 1'b1;
		ar[p].addr = a;
		#1;
		while (!ar_ready[p]) begin
			@(negedge clk);
			#1;
		end
		acc = cycle;  // The cycle of the ar transfer orders the paired grants
		@(negedge clk);
		ar_valid[p] = 1'b0;
		take_resp(p, 1'b1, stall, got);
	endtask

	task automatic do_write(input int p, input row_t row, input int stall,
			output axi_lite_pkg::r_t got);
		bit aw_done;
		bit w_done;
		aw_done = 0;
		w_done = 0;
		@(negedge clk);
		aw_valid[p] = 1'b1;
		aw[p].addr = row.addr;
		w_valid[p] = 1'b1;
		w[p].data = row.data;
		w[p].strb = row.strb;
		while (!(aw_done && w_done)) begin
			#1;
			if (aw_valid[p] && aw_ready[p])
				aw_done = 1;
			if (w_valid[p] && w_ready[p])
				w_done = 1;
			@(negedge clk);
			if (aw_done)
				aw_valid[p] = 1'b0;
			if (w_done)
				w_valid[p] = 1'b0;
		end
		take_resp(p, 1'b0, stall, got);
	endtask

	task automatic expect_read(input int p, input axi_lite_pkg::addr_t a,
			input axi_lite_pkg::r_t got);
		axi_lite_pkg::r_t exp;
		exp.resp = in_window(a) ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
		exp.data = in_window(a) ? shadow[(a - MEM_BASE) >> 2] : '0;
		check($sformatf("m%0d_r.resp", p), 64'(exp.resp), 64'(got.resp));
		check($sformatf("m%0d_r.data", p), 64'(exp.data), 64'(got.data));
	endtask

	// Merges the strobed bytes into the shadow and checks the write response
	task automatic expect_write(input int p, input row_t row, input axi_lite_pkg::r_t got);
		axi_lite_pkg::resp_e exp;
		exp = in_window(row.addr) ? axi_lite_pkg::OKAY : axi_lite_pkg::SLVERR;
		if (in_window(row.addr)) begin
			for (int i = 0; i < 4; i++) begin
				if (row.strb[i])
					shadow[(row.addr - MEM_BASE) >> 2][8*i +: 8] = row.data[8*i +: 8];
			end
		end
		check($sformatf("m%0d_b.resp", p), 64'(exp), 64'(got.resp));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		axi_lite_pkg::r_t got0;
		axi_lite_pkg::r_t got1;
		int acc0;
		int acc1;
		int stall0;
		int stall1;
		int p;
		int last_rd;
		int first_exp;
		int errs_before;
		int exp_r;
		int exp_b;
		int row_pass;
		int row_fail;
		reset = 1'b1;
		for (int i = 0; i < 2; i++) begin
			ar_valid[i] = 1'b0;
			ar[i] = '0;
			aw_valid[i] = 1'b0;
			aw[i] = '0;
			w_valid[i] = 1'b0;
			w[i] = '0;
			r_ready[i] = 1'b0;
			b_ready[i] = 1'b0;
		end
		for (int i = 0; i < MEM_WORDS; i++)
			shadow[i] = '0;
		last_rd = 1;  // Nobody has won yet, so m0 takes the first tie
		first_exp = 0;
		exp_r = 0;
		exp_b = 0;
		row_pass = 0;
		row_fail = 0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		#1;
		for (int i = 0; i < 2; i++) begin
			check($sformatf("m%0d_ar_ready", i), 64'(1), 64'(ar_ready[i]));
			check($sformatf("m%0d_aw_ready", i), 64'(1), 64'(aw_ready[i]));
			check($sformatf("m%0d_w_ready", i), 64'(1), 64'(w_ready[i]));
			check($sformatf("m%0d_r_valid", i), 64'(0), 64'(r_valid[i]));
			check($sformatf("m%0d_b_valid", i), 64'(0), 64'(b_valid[i]));
		end
		$display("reset state: %s", (errors == 0) ? "ok" : "mismatch");

		for (int i = 0; i < NUM_ROWS; i++) begin
			errs_before = errors;
			p = int'(ROWS[i].port);
			stall0 = rand_bits(2);
			case (ROWS[i].op)
				OP_WR: begin
					do_write(p, ROWS[i], stall0, got0);
					expect_write(p, ROWS[i], got0);
					exp_b++;
				end
				OP_RD: begin
					do_read(p, ROWS[i].addr, stall0, got0, acc0);
					expect_read(p, ROWS[i].addr, got0);
					last_rd = p;
					exp_r++;
				end
				default: begin
					stall1 = rand_bits(2);
					first_exp = (last_rd == 0) ? 1 : 0;  // The loser of the previous read goes first
					fork
						do_read(0, ROWS[i].addr, stall0, got0, acc0);
						do_read(1, ROWS[i].addr + 32'h4, stall1, got1, acc1);
					join
					expect_read(0, ROWS[i].addr, got0);
					expect_read(1, ROWS[i].addr + 32'h4, got1);
					check("first paired grant", 64'(first_exp),
						64'((acc0 < acc1) ? 0 : 1));
					last_rd = 1 - first_exp;  // The second grant of the pair won last
					exp_r += 2;
				end
			endcase
			if (errors == errs_before)
				row_pass++;
			else
				row_fail++;
			$display("row %0d %s m%0d %h: %s", i, ROWS[i].op.name(), p, ROWS[i].addr,
				(errors == errs_before) ? "ok" : "mismatch");
		end

		repeat (2) @(negedge clk);
		check("r transfer count", 64'(exp_r), 64'(r_seen));
		check("b transfer count", 64'(exp_b), 64'(b_seen));
		$display("%0d rows passed, %0d rows failed, %0d errors", row_pass, row_fail, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- tb.f
hw/axi_lite_pkg.sv
hw/resp_delay.sv
hw/sram_axi.sv
hw/axi_lite_arbiter.sv
hw/mem_subsys_top.sv
tests/tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_mem_subsys

./obj_dir/Vtb_mem_subsys > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
	exit 1
fi
exit 0
